/* hdl/cache_geometry_pkg.sv */
// cache geometry constants
// describes how a word address splits into tag, set and offset, and the line size

package cache_geometry_pkg;

	// addresses count 32-bit words, not bytes
	localparam int addr_width = 16;
	localparam int word_width = 32;

	// low address bits pick a word within the line
	localparam int offset_width = 2;

	// middle bits index the direct-mapped sets
	localparam int set_width = 5;

	// whatever is left at the top is kept as the tag
	localparam int tag_width = addr_width - set_width - offset_width;

	localparam int num_sets = 2 ** set_width;
	localparam int words_per_line = 2 ** offset_width;

	// a whole line moves as one word on the refill path
	localparam int line_width = words_per_line * word_width;

endpackage

/* hdl/cache_types_pkg.sv */
// cache interface types
// packed structs and the address union passed between the cache blocks and memory

package cache_types_pkg;

	// field view of a word address, tag in the top bits
	typedef struct packed {
		logic [cache_geometry_pkg::tag_width-1:0] tag;
		logic [cache_geometry_pkg::set_width-1:0] set;
		logic [cache_geometry_pkg::offset_width-1:0] offset;
	} addr_fields_t;

	// the requester sees a flat address, the cache looks at its fields
	typedef union packed {
		logic [cache_geometry_pkg::addr_width-1:0] raw;
		addr_fields_t fields;
	} cache_addr_t;

	// one lookup per cycle, valid is a single-cycle strobe
	typedef struct packed {
		logic valid;
		cache_addr_t addr;
	} lookup_req_t;

	// data only means something when hit is set
	typedef struct packed {
		logic valid;
		logic hit;
		cache_addr_t addr;
		logic [cache_geometry_pkg::word_width-1:0] data;
	} lookup_resp_t;

	// line address of the miss being refilled
	typedef struct packed {
		logic valid;
		logic [cache_geometry_pkg::tag_width-1:0] tag;
		logic [cache_geometry_pkg::set_width-1:0] set;
	} mem_req_t;

	// returned line, word 0 sits in the low bits
	typedef struct packed {
		logic valid;
		logic [cache_geometry_pkg::line_width-1:0] line;
	} mem_fill_t;

	// write into both the tag and the data array at the same edge
	typedef struct packed {
		logic valid;
		logic [cache_geometry_pkg::set_width-1:0] set;
		logic [cache_geometry_pkg::tag_width-1:0] tag;
		logic [cache_geometry_pkg::line_width-1:0] line;
	} array_fill_t;

endpackage

/* hdl/sram_1r1w.sv */
// one-read one-write block SRAM
// synchronous read with the data registered, a same-address write is forwarded

`timescale 1ns/1ns

module sram_1r1w
	#(parameter int data_width = 32,
	parameter int size = 32)

	(input clk,
	input logic rd_enable,
	input logic [$clog2(size)-1:0] rd_addr,
	output logic [data_width-1:0] rd_data,
	input logic wr_enable,
	input logic [$clog2(size)-1:0] wr_addr,
	input logic [data_width-1:0] wr_data);

	// storage array, there is no reset so a block RAM can be inferred
	logic [data_width-1:0] data [0:size-1];

	// the old and the new contents would both be legal on a collision,
	// this block promises the new one to its users
	logic collide;

	assign collide = wr_enable && rd_enable && (wr_addr == rd_addr);

	always_ff @(posedge clk)
	begin
		if (wr_enable)
			data[wr_addr] <= wr_data;
	end

	// read data holds its last value while rd_enable is low
	always_ff @(posedge clk)
	begin
		if (collide)
			rd_data <= wr_data;
		else if (rd_enable)
			rd_data <= data[rd_addr];
	end

endmodule

/* hdl/cache_tag_array.sv */
// tag array of the direct-mapped cache
// tags live in an SRAM, the valid flags in flip-flops so that reset can clear them

`timescale 1ns/1ns

module cache_tag_array
	(input clk,
	input reset,
	input logic rd_enable,
	input logic [cache_geometry_pkg::set_width-1:0] rd_set,
	output logic [cache_geometry_pkg::tag_width-1:0] rd_tag,
	output logic rd_valid,
	input cache_types_pkg::array_fill_t fill);

	// one flag per set, set by a fill and cleared only by reset
	logic [cache_geometry_pkg::num_sets-1:0] valid_bits;

	// a fill to the set being read wins, same rule as the SRAM
	logic fill_hits_read;

	assign fill_hits_read = fill.valid && (fill.set == rd_set);

	// tag storage, written with every fill
	sram_1r1w #(
		.data_width(cache_geometry_pkg::tag_width),
		.size(cache_geometry_pkg::num_sets)
	) tag_sram (
		.clk(clk),
		.rd_enable(rd_enable),
		.rd_addr(rd_set),
		.rd_data(rd_tag),
		.wr_enable(fill.valid),
		.wr_addr(fill.set),
		.wr_data(fill.tag)
	);

	always_ff @(posedge clk)
	begin
		if (reset)
			valid_bits <= '0;
		else if (fill.valid)
			valid_bits[fill.set] <= 1'b1;
	end

	// the flag read is registered so it lines up with rd_tag from the SRAM
	always_ff @(posedge clk)
	begin
		if (reset)
			rd_valid <= 1'b0;
		else if (rd_enable)
		begin
			// a line never goes invalid except through reset,
			// so forwarding only ever has to report a one
			if (fill_hits_read)
				rd_valid <= 1'b1;
			else
				rd_valid <= valid_bits[rd_set];
		end
	end

endmodule

/* hdl/cache_lookup.sv */
// lookup pipeline of the cache
// reads tag and line in the request cycle, compares and picks the word one cycle later

`timescale 1ns/1ns

module cache_lookup
	(input clk,
	input reset,
	input cache_types_pkg::lookup_req_t lookup_req,
	input cache_types_pkg::array_fill_t fill,
	output cache_types_pkg::lookup_resp_t lookup_resp);

	// request held for the compare stage
	logic req_valid_q;
	cache_types_pkg::cache_addr_t req_addr_q;

	// array outputs, they belong to the request in req_addr_q
	logic [cache_geometry_pkg::tag_width-1:0] stored_tag;
	logic stored_valid;
	logic [cache_geometry_pkg::line_width-1:0] stored_line;

	// the line seen as separate words so that the offset can index it
	logic [cache_geometry_pkg::words_per_line-1:0][cache_geometry_pkg::word_width-1:0]
		line_words;

	logic tag_match;

	// stage one: both arrays take the set field straight from the request
	cache_tag_array tag_array (
		.clk(clk),
		.reset(reset),
		.rd_enable(lookup_req.valid),
		.rd_set(lookup_req.addr.fields.set),
		.rd_tag(stored_tag),
		.rd_valid(stored_valid),
		.fill(fill)
	);

	// data array holds whole lines, the fill writes one line per set
	sram_1r1w #(
		.data_width(cache_geometry_pkg::line_width),
		.size(cache_geometry_pkg::num_sets)
	) data_sram (
		.clk(clk),
		.rd_enable(lookup_req.valid),
		.rd_addr(lookup_req.addr.fields.set),
		.rd_data(stored_line),
		.wr_enable(fill.valid),
		.wr_addr(fill.set),
		.wr_data(fill.line)
	);

	always_ff @(posedge clk)
	begin
		if (reset)
			req_valid_q <= 1'b0;
		else
			req_valid_q <= lookup_req.valid;
	end

	// the address is payload and only matters while req_valid_q is set
	always_ff @(posedge clk)
	begin
		if (lookup_req.valid)
			req_addr_q <= lookup_req.addr;
	end

	// stage two: tag compare and word select
	assign tag_match = stored_valid && (stored_tag == req_addr_q.fields.tag);
	assign line_words = stored_line;

	always_comb
	begin
		lookup_resp.valid = req_valid_q;
		lookup_resp.hit = tag_match;
		lookup_resp.addr = req_addr_q;

		// on a miss this is whatever the set held, the requester ignores it
		lookup_resp.data = line_words[req_addr_q.fields.offset];
	end

endmodule

/* hdl/cache_miss_unit.sv */
// miss handling for the cache
// tracks the one outstanding miss, requests its line and turns the reply into a fill

`timescale 1ns/1ns

module cache_miss_unit
	(input clk,
	input reset,
	input cache_types_pkg::lookup_resp_t lookup_resp,
	input cache_types_pkg::mem_fill_t mem_fill,
	output cache_types_pkg::mem_req_t mem_req,
	output cache_types_pkg::array_fill_t fill);

	// high from the miss until its line comes back
	logic pending;

	// line address of the outstanding miss
	logic [cache_geometry_pkg::tag_width-1:0] miss_tag;
	logic [cache_geometry_pkg::set_width-1:0] miss_set;

	logic req_valid_q;

	// only the first miss is taken, later ones are dropped and the requester retries
	logic new_miss;

	assign new_miss = lookup_resp.valid && !lookup_resp.hit && !pending;

	always_ff @(posedge clk)
	begin
		if (reset)
			pending <= 1'b0;
		else if (mem_fill.valid)
			pending <= 1'b0;
		else if (new_miss)
			pending <= 1'b1;
	end

	// latched at the same edge that raises the request
	always_ff @(posedge clk)
	begin
		if (new_miss)
		begin
			miss_tag <= lookup_resp.addr.fields.tag;
			miss_set <= lookup_resp.addr.fields.set;
		end
	end

	// one-cycle strobe towards memory, the line address stays put behind it
	always_ff @(posedge clk)
	begin
		if (reset)
			req_valid_q <= 1'b0;
		else
			req_valid_q <= new_miss;
	end

	assign mem_req.valid = req_valid_q;
	assign mem_req.tag = miss_tag;
	assign mem_req.set = miss_set;

	// the fill goes out in the same cycle as the reply so the arrays write at that edge.
	// a reply with nothing pending, e.g. one that was asked for before a reset, is dropped
	always_comb
	begin
		fill.valid = mem_fill.valid && pending;
		fill.set = miss_set;
		fill.tag = miss_tag;
		fill.line = mem_fill.line;
	end

endmodule

/* hdl/l1_cache.sv */
// direct-mapped read cache, top level
// joins the lookup pipeline to the miss unit that refills it from memory

`timescale 1ns/1ns

module l1_cache
	(input clk,
	input reset,
	input cache_types_pkg::lookup_req_t lookup_req,
	output cache_types_pkg::lookup_resp_t lookup_resp,
	output cache_types_pkg::mem_req_t mem_req,
	input cache_types_pkg::mem_fill_t mem_fill);

	// refill write from the miss unit into both arrays
	cache_types_pkg::array_fill_t array_fill;

	// answers every lookup one cycle after it is sampled
	cache_lookup lookup (
		.clk(clk),
		.reset(reset),
		.lookup_req(lookup_req),
		.fill(array_fill),
		.lookup_resp(lookup_resp)
	);

	// watches the responses for misses and drives the memory side
	cache_miss_unit miss_unit (
		.clk(clk),
		.reset(reset),
		.lookup_resp(lookup_resp),
		.mem_fill(mem_fill),
		.mem_req(mem_req),
		.fill(array_fill)
	);

endmodule

/* verif/l1_cache_assertions.sv */
// protocol checks for the cache top level
// bound into l1_cache, they watch the request and refill strobes at its ports

`timescale 1ns/1ns

module l1_cache_assertions
	(input clk,
	input reset,
	input cache_types_pkg::lookup_req_t lookup_req,
	input cache_types_pkg::lookup_resp_t lookup_resp,
	input cache_types_pkg::mem_req_t mem_req,
	input cache_types_pkg::mem_fill_t mem_fill);

	// open from a memory request until its line comes back
	logic refill_open;

	always_ff @(posedge clk)
	begin
		if (reset)
			refill_open <= 1'b0;
		else if (mem_fill.valid)
			refill_open <= 1'b0;
		else if (mem_req.valid)
			refill_open <= 1'b1;
	end

	// the request towards memory is a single-cycle strobe
	req_is_strobe: assert property (@(posedge clk) disable iff (reset)
		mem_req.valid |=> !mem_req.valid)
		else $error("mem_req.valid stayed high for more than one cycle");

	// only one miss may be outstanding at a time
	one_refill_only: assert property (@(posedge clk) disable iff (reset)
		mem_req.valid |-> !refill_open)
		else $error("mem_req raised while an earlier refill was still open");

	// every lookup is answered exactly one cycle later
	resp_after_one_cycle: assert property (@(posedge clk) disable iff (reset)
		lookup_req.valid |=> lookup_resp.valid)
		else $error("lookup_req was not answered one cycle later");

endmodule

bind l1_cache l1_cache_assertions checks (
	.clk(clk),
	.reset(reset),
	.lookup_req(lookup_req),
	.lookup_resp(lookup_resp),
	.mem_req(mem_req),
	.mem_fill(mem_fill)
);

/* verif/l1_cache_tb.sv */
// testbench for the direct-mapped read cache
// drives lookups, models a memory with random latency and checks every response

`timescale 1ns/1ns

module l1_cache_tb;

	typedef logic [cache_geometry_pkg::addr_width-1:0] word_addr_t;
	typedef logic [cache_geometry_pkg::word_width-1:0] word_t;
	typedef logic [cache_geometry_pkg::line_width-1:0] line_t;
	typedef enum logic [1:0] {want_miss, want_hit, want_any} outcome_t;
	typedef struct packed {
		word_addr_t addr;
		outcome_t outcome;
	} pend_t;

	logic clk;
	logic reset;
	cache_types_pkg::lookup_req_t lookup_req;
	cache_types_pkg::lookup_resp_t lookup_resp;
	cache_types_pkg::mem_req_t mem_req;
	cache_types_pkg::mem_fill_t mem_fill;

	// outcome the stimulus expects for the request it is driving
	outcome_t req_outcome;
	// queue of requests seen on the port and what each one should return
	pend_t expect_q [$];
	logic last_hit;
	// model of the single outstanding miss
	logic model_pending;
	cache_types_pkg::cache_addr_t miss_addr;
	int miss_count;
	// model of the cache contents, one tag and one valid flag per set
	logic [cache_geometry_pkg::tag_width-1:0] model_tag [cache_geometry_pkg::num_sets];
	logic [cache_geometry_pkg::num_sets-1:0] model_valid;
	// the memory will drive its line one cycle from now
	logic fill_next;
	logic [31:0] mem_rand;
	logic [31:0] addr_rand;
	cache_types_pkg::cache_addr_t a;

	l1_cache dut (
		.clk(clk),
		.reset(reset),
		.lookup_req(lookup_req),
		.lookup_resp(lookup_resp),
		.mem_req(mem_req),
		.mem_fill(mem_fill)
	);

	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s ^ (s << 13);
		x = x ^ (x >> 17);
		return x ^ (x << 5);
	endfunction

	// every word address owns a fixed hashed value and this is what memory holds
	function automatic word_t ref_word(input word_addr_t addr);
		word_t h;
		h = {addr, ~addr} ^ 32'h9e3779b9;
		h = h ^ (h << 7);
		return h ^ (h >> 11) ^ 32'h5bd1e995;
	endfunction

	// word 0 of the line goes in the low bits
	function automatic line_t build_line(input cache_types_pkg::mem_req_t req);
		line_t line;
		cache_types_pkg::cache_addr_t addr;
		addr.fields.tag = req.tag;
		addr.fields.set = req.set;
		for (int w = 0; w < cache_geometry_pkg::words_per_line; w++)
		begin
			addr.fields.offset = w[cache_geometry_pkg::offset_width-1:0];
			line[w*cache_geometry_pkg::word_width +: cache_geometry_pkg::word_width] =
				ref_word(addr.raw);
		end
		return line;
	endfunction

	task automatic report_failure(input string msg);
		$display("%s", msg);
		$display("STATUS: FAIL");
		$fatal(1, "testbench stopped at the first error");
	endtask

	task automatic compare_lookup_resp(input string name,
		input cache_types_pkg::lookup_resp_t actual,
		input cache_types_pkg::lookup_resp_t expected);
		if (actual !== expected)
			report_failure($sformatf("CHECK FAILED at %0t ns: %s is %h, expected %h",
				$time, name, actual, expected));
	endtask

	task automatic compare_mem_req(input string name,
		input cache_types_pkg::mem_req_t actual,
		input cache_types_pkg::mem_req_t expected);
		if (actual !== expected)
			report_failure($sformatf("CHECK FAILED at %0t ns: %s is %h, expected %h",
				$time, name, actual, expected));
	endtask

	// the memory model answers each request after 1 to 8 cycles
	initial
	begin
		int countdown;
		int served;
		logic in_reset;
		cache_types_pkg::mem_req_t expected_req;
		cache_types_pkg::mem_req_t open_req;
		mem_fill = '0;
		fill_next = 1'b0;
		countdown = 0;
		served = 0;
		mem_rand = 32'h341de093;
		forever
		begin
			@(posedge clk);
			in_reset = reset;
			#1;
			mem_fill.valid = 1'b0;
			if (in_reset)
			begin
				countdown = 0;
				served = 0;
			end
			else
			begin
				if (countdown > 0)
				begin
					countdown = countdown - 1;
					if (countdown == 0)
					begin
						mem_fill.valid = 1'b1;
						mem_fill.line = build_line(open_req);
					end
				end
				// the request must follow the first unserved miss by exactly one cycle
				if (mem_req.valid === 1'b1)
				begin
					if (served == miss_count)
						report_failure("memory request raised with no new miss to serve");
					else if (countdown > 0)
						report_failure("memory request raised while a refill was pending");
					else
					begin
						expected_req.valid = 1'b1;
						expected_req.tag = miss_addr.fields.tag;
						expected_req.set = miss_addr.fields.set;
						compare_mem_req("mem_req", mem_req, expected_req);
						open_req = mem_req;
						served = served + 1;
						mem_rand = xorshift(mem_rand);
						countdown = int'(mem_rand[2:0]) + 1;
					end
				end
				else if (served != miss_count)
					report_failure("a new miss was not followed by a memory request");
			end
			fill_next = (countdown == 1);
		end
	end

	// the comparing process samples mid-cycle where all outputs have settled
	always @(negedge clk)
	begin
		pend_t entry;
		cache_types_pkg::cache_addr_t entry_addr;
		cache_types_pkg::lookup_resp_t expected;
		if (reset)
		begin
			expect_q.delete();
			model_pending = 1'b0;
			model_valid = '0;
			miss_count = 0;
		end
		else
		begin
			if (lookup_resp.valid === 1'b1)
			begin
				if (expect_q.size() == 0)
					report_failure("lookup response arrived with no request outstanding");
				else
				begin
					entry = expect_q.pop_front();
					entry_addr.raw = entry.addr;
					expected.valid = 1'b1;
					expected.addr.raw = entry.addr;
					// random lookups take their outcome from the model of the contents
					if (entry.outcome == want_any)
						expected.hit = model_valid[entry_addr.fields.set] &&
							(model_tag[entry_addr.fields.set] == entry_addr.fields.tag);
					else
						expected.hit = (entry.outcome == want_hit);
					// data is only defined on a hit
					expected.data = expected.hit ? ref_word(entry.addr) : lookup_resp.data;
					compare_lookup_resp("lookup_resp", lookup_resp, expected);
					last_hit = lookup_resp.hit;
					if (!lookup_resp.hit && !model_pending)
					begin
						model_pending = 1'b1;
						miss_addr.raw = entry.addr;
						miss_count = miss_count + 1;
					end
				end
			end
			if (lookup_req.valid)
			begin
				entry.addr = lookup_req.addr.raw;
				entry.outcome = req_outcome;
				expect_q.push_back(entry);
			end
			// since a miss in the fill cycle itself is still dropped this comes last
			if (mem_fill.valid && model_pending)
			begin
				model_tag[miss_addr.fields.set] = miss_addr.fields.tag;
				model_valid[miss_addr.fields.set] = 1'b1;
				model_pending = 1'b0;
			end
		end
	end

	// the stimulus tasks start and end 1 ns after a rising edge
	task automatic issue(input word_addr_t addr, input outcome_t outcome);
		lookup_req.valid = 1'b1;
		lookup_req.addr.raw = addr;
		req_outcome = outcome;
		@(posedge clk);
		#1;
		lookup_req.valid = 1'b0;
	endtask

	task automatic drain();
		int cycles;
		cycles = 0;
		while (expect_q.size() != 0)
		begin
			@(posedge clk);
			#1;
			cycles = cycles + 1;
			if (cycles > 20)
				report_failure("timeout waiting for the lookup responses");
		end
	endtask

	task automatic wait_refill();
		int cycles;
		cycles = 0;
		while (model_pending)
		begin
			@(posedge clk);
			#1;
			cycles = cycles + 1;
			if (cycles > 20)
				report_failure("timeout waiting for the refill from memory");
		end
	endtask

	task automatic retry_until_hit(input word_addr_t addr);
		int tries;
		tries = 0;
		last_hit = 1'b0;
		while (!last_hit)
		begin
			if (tries == 20)
				report_failure("timeout while retrying a lookup that never hit");
			issue(addr, want_any);
			drain();
			tries = tries + 1;
		end
	endtask

	task automatic apply_reset();
		reset = 1'b1;
		repeat (4) @(posedge clk);
		#1;
		reset = 1'b0;
	endtask

	initial
	begin
		int cycles;
		lookup_req = '0;
		req_outcome = want_any;
		addr_rand = 32'h341de093;
		apply_reset();

		// cold miss and refill, then the retry hits
		issue(16'h1234, want_miss);
		drain();
		wait_refill();
		issue(16'h1234, want_hit);
		drain();

		// all four words of the line are looked up on consecutive cycles
		a.raw = 16'h1234;
		for (int w = 0; w < cache_geometry_pkg::words_per_line; w++)
		begin
			a.fields.offset = w[cache_geometry_pkg::offset_width-1:0];
			issue(a.raw, want_hit);
		end
		drain();

		// 16'h12b4 shares the set of 16'h1234 with another tag
		issue(16'h12b4, want_miss);
		drain();
		wait_refill();
		issue(16'h1234, want_miss);
		issue(16'h12b5, want_hit);
		drain();
		wait_refill();

		// lookup sampled at the same edge as the fill sees the new line
		issue(16'h2a51, want_miss);
		drain();
		cycles = 0;
		while (!fill_next)
		begin
			@(negedge clk);
			cycles = cycles + 1;
			if (cycles > 20)
				report_failure("timeout waiting for memory to return the line");
		end
		@(posedge clk);
		#1;
		issue(16'h2a53, want_hit);
		drain();

		// a mid-test reset drops every valid line
		issue(16'h1236, want_hit);
		drain();
		apply_reset();
		issue(16'h1236, want_miss);
		drain();
		wait_refill();
		issue(16'h1236, want_hit);
		drain();

		// random addresses over four tags and four sets are retried until they hit
		repeat (40)
		begin
			addr_rand = xorshift(addr_rand);
			retry_until_hit(addr_rand[cache_geometry_pkg::addr_width-1:0] & 16'h018f);
		end

		$display("STATUS: PASS");
		$finish;
	end

endmodule

/* l1_cache.f */
hdl/cache_geometry_pkg.sv
hdl/cache_types_pkg.sv
hdl/sram_1r1w.sv
hdl/cache_tag_array.sv
hdl/cache_lookup.sv
hdl/cache_miss_unit.sv
hdl/l1_cache.sv
verif/l1_cache_assertions.sv
verif/l1_cache_tb.sv

/* Makefile */
VERILATOR ?= verilator
VERILATOR_FLAGS = --binary --timing --assert -j 0
TOP = l1_cache_tb
FILELIST = l1_cache.f
BUILD_DIR = obj_dir
PASS_TEXT = STATUS: PASS

.PHONY: help test clean

help:
	@echo "make targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VERILATOR_FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out=$$(./$(BUILD_DIR)/V$(TOP)); echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
